// File: src/dist_pkg.sv
/*
 * Shared types and constants for the frame distributor.
 * Frame word structs, MI32 register map, default sizes.
 */

`default_nettype none

package dist_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------

  // Channel address width
  localparam int CHAN_W = 2;
  // Default number of channels
  localparam int CHAN_COUNT = 1 << CHAN_W;
  // Default per-channel buffer depth in words
  localparam int DEF_BUF_DEPTH = 16;

  // --------------------------------------------------------------------------
  // Stream payloads
  // --------------------------------------------------------------------------

  // One FrameLink word
  typedef struct packed {
    logic [31:0] data;
    logic        sof;
    logic        eof;
    logic [1:0]  rem;   // Valid bytes minus one in the eof word
  } fl_word_t;

  // Transmit word tagged with its source channel
  typedef struct packed {
    logic [CHAN_W-1:0] chan;
    fl_word_t          word;
  } tx_word_t;

  // --------------------------------------------------------------------------
  // MI32 register map
  // --------------------------------------------------------------------------

  localparam logic [31:0] MI_ADDR_ENABLE       = 32'h0000_0000;
  localparam logic [31:0] MI_ADDR_INT          = 32'h0000_0004;
  localparam logic [31:0] MI_ADDR_DISCARD_BASE = 32'h0000_0010;
  // Byte distance between discard counters
  localparam int          MI_DISCARD_STRIDE    = 4;

endpackage

`default_nettype wire

// File: src/rx_dispatch.sv
/*
 * Receive dispatcher. Locks each frame to its channel, drops frames
 * for disabled channels, spends per-channel buffer credits.
 */

`timescale 1ns/100ps
`default_nettype none

module rx_dispatch #(
  parameter int CHAN_COUNT = dist_pkg::CHAN_COUNT,
  parameter int BUF_DEPTH  = dist_pkg::DEF_BUF_DEPTH
) (
  input  wire                          clk,
  input  wire                          arst_n,
  // Receive stream
  input  wire dist_pkg::fl_word_t      rx_word,
  input  wire [dist_pkg::CHAN_W-1:0]   rx_chan,
  input  wire                          rx_valid,
  output logic                         rx_ready,
  // Channel enable mask from the register block
  input  wire [CHAN_COUNT-1:0]         chan_enable,
  // Buffer write side
  output dist_pkg::fl_word_t           buf_wr_word,
  output logic [CHAN_COUNT-1:0]        buf_wr_en,
  input  wire [CHAN_COUNT-1:0]         buf_credit_ret,
  // Frame events
  output logic                         discard_pulse,
  output logic [dist_pkg::CHAN_W-1:0]  discard_chan,
  output logic                         rx_frame_pulse
);

  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  // Per-frame lock
  logic                        in_frame;
  logic [dist_pkg::CHAN_W-1:0] lock_chan;
  logic                        lock_drop;
  // Holds rx_ready low until the first cycle after reset
  logic                        ready_en;

  // Free words left in each buffer
  logic [CNT_W-1:0]            credit [CHAN_COUNT];

  logic [dist_pkg::CHAN_W-1:0] cur_chan;
  logic                        cur_drop;
  logic                        accept;
  logic                        take;
  logic [CHAN_COUNT-1:0]       spend;

  // --------------------------------------------------------------------------
  // Channel and drop decision for the word on the bus
  // --------------------------------------------------------------------------

  // Outside a frame the sof word decides, inside the lock holds
  always_comb begin
    cur_chan = in_frame ? lock_chan : rx_chan;
    cur_drop = in_frame ? lock_drop : ~chan_enable[rx_chan];
  end

  // Dropped frames are swallowed without credit
  assign rx_ready = ready_en & (cur_drop | (credit[cur_chan] != '0));
  assign accept   = rx_valid & rx_ready;
  assign take     = accept & ~cur_drop;

  always_comb begin
    spend           = '0;
    spend[cur_chan] = take;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_en  <= 1'b0;
      in_frame  <= 1'b0;
      lock_chan <= '0;
      lock_drop <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      if (accept) begin
        in_frame  <= ~rx_word.eof;
        lock_chan <= cur_chan;
        lock_drop <= cur_drop;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Credit counters
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < CHAN_COUNT; i++) begin
        credit[i] <= CNT_W'(BUF_DEPTH);
      end
    end else begin
      for (int i = 0; i < CHAN_COUNT; i++) begin
        // Spend and return in the same cycle cancel out
        case ({spend[i], buf_credit_ret[i]})
          2'b10:   credit[i] <= credit[i] - 1'b1;
          2'b01:   credit[i] <= credit[i] + 1'b1;
          default: credit[i] <= credit[i];
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Registered buffer write and frame events
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      buf_wr_en      <= '0;
      discard_pulse  <= 1'b0;
      discard_chan   <= '0;
      rx_frame_pulse <= 1'b0;
    end else begin
      buf_wr_en      <= spend;
      discard_pulse  <= accept & cur_drop & rx_word.eof;
      rx_frame_pulse <= take & rx_word.eof;
      if (accept && cur_drop && rx_word.eof) begin
        discard_chan <= cur_chan;
      end
    end
  end

  // Write data shared by all buffers
  always_ff @(posedge clk) begin
    if (take) begin
      buf_wr_word <= rx_word;
    end
  end

endmodule

`default_nettype wire

// File: src/chan_buffer.sv
/*
 * Per-channel word FIFO. Sized by credits so no full flag,
 * one credit returned per popped word.
 */

`timescale 1ns/100ps
`default_nettype none

module chan_buffer #(
  parameter int BUF_DEPTH = dist_pkg::DEF_BUF_DEPTH
) (
  input  wire                     clk,
  input  wire                     arst_n,
  // Write side from the dispatcher
  input  wire dist_pkg::fl_word_t wr_word,
  input  wire                     wr_en,
  // Read side to the drain
  output dist_pkg::fl_word_t      head_word,
  output logic                    head_valid,
  input  wire                     pop,
  // Credit back to the dispatcher
  output logic                    credit_ret
);

  localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CW = $clog2(BUF_DEPTH + 1);

  // Word storage
  dist_pkg::fl_word_t mem [BUF_DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_pop;

  // Pointer step with wrap for any depth
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    if (p == AW'(BUF_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Pop of an empty buffer is ignored
  assign do_pop     = pop & head_valid;
  assign head_valid = (count != '0);
  assign head_word  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // --------------------------------------------------------------------------
  // Pointers, occupancy, credit return
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_ret <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_ret <= do_pop;
    end
  end

endmodule

`default_nettype wire

// File: src/tx_drain.sv
/*
 * Round-robin drain of whole frames from the channel buffers
 * onto the transmit stream, each word tagged with its channel.
 */

`timescale 1ns/100ps
`default_nettype none

module tx_drain #(
  parameter int CHAN_COUNT = dist_pkg::CHAN_COUNT
) (
  input  wire                     clk,
  input  wire                     arst_n,
  // Buffer heads
  input  wire dist_pkg::fl_word_t head_word [CHAN_COUNT],
  input  wire [CHAN_COUNT-1:0]    head_valid,
  output logic [CHAN_COUNT-1:0]   pop,
  // Transmit stream
  output dist_pkg::tx_word_t      tx_word,
  output logic                    tx_valid,
  input  wire                     tx_ready,
  // Delivered frame event
  output logic                    tx_frame_pulse
);

  localparam int CW = dist_pkg::CHAN_W;

  // Lock state and round-robin pointer
  logic          locked;
  logic [CW-1:0] lock_chan;
  logic [CW-1:0] rr_ptr;

  // Candidate for the next lock
  logic          pick_found;
  logic [CW-1:0] pick_chan;
  logic          xfer;

  // Next channel in rotation
  function automatic logic [CW-1:0] chan_inc(input logic [CW-1:0] c);
    if (c == CW'(CHAN_COUNT - 1)) begin
      return '0;
    end
    return c + 1'b1;
  endfunction

  // --------------------------------------------------------------------------
  // Channel search
  // --------------------------------------------------------------------------

  // First channel at or after the pointer with a frame start at its head
  always_comb begin : pick
    int idx;
    pick_found = 1'b0;
    pick_chan  = rr_ptr;
    // Walk backwards so the nearest match is written last
    for (int k = CHAN_COUNT - 1; k >= 0; k--) begin
      idx = (int'(rr_ptr) + k) % CHAN_COUNT;
      if (head_valid[idx] && head_word[idx].sof) begin
        pick_found = 1'b1;
        pick_chan  = CW'(idx);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Forwarding path
  // --------------------------------------------------------------------------

  // Straight from the locked head so frame words go back to back
  assign tx_valid       = locked & head_valid[lock_chan];
  assign tx_word.chan   = lock_chan;
  assign tx_word.word   = head_word[lock_chan];
  assign xfer           = tx_valid & tx_ready;
  assign tx_frame_pulse = xfer & tx_word.word.eof;

  always_comb begin
    pop            = '0;
    pop[lock_chan] = xfer;
  end

  // Idle cycle locks, eof transfer unlocks and moves the pointer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      locked    <= 1'b0;
      lock_chan <= '0;
      rr_ptr    <= '0;
    end else if (!locked) begin
      if (pick_found) begin
        locked    <= 1'b1;
        lock_chan <= pick_chan;
      end
    end else if (tx_frame_pulse) begin
      locked <= 1'b0;
      rr_ptr <= chan_inc(lock_chan);
    end
  end

endmodule

`default_nettype wire

// File: src/mi_status.sv
/*
 * MI32 register block. Channel enable mask, read-only discard
 * counters, sticky RX/TX interrupt bits with write-one-to-clear.
 */

`timescale 1ns/100ps
`default_nettype none

module mi_status #(
  parameter int CHAN_COUNT = dist_pkg::CHAN_COUNT
) (
  input  wire                         clk,
  input  wire                         arst_n,
  // MI32 slave
  input  wire [31:0]                  mi_addr,
  input  wire [31:0]                  mi_dwr,
  input  wire                         mi_wr,
  input  wire                         mi_rd,
  output logic                        mi_ardy,
  output logic [31:0]                 mi_drd,
  output logic                        mi_drdy,
  // Control and events
  output logic [CHAN_COUNT-1:0]       chan_enable,
  input  wire                         discard_pulse,
  input  wire [dist_pkg::CHAN_W-1:0]  discard_chan,
  input  wire                         rx_frame_pulse,
  input  wire                         tx_frame_pulse,
  output logic                        rx_interrupt,
  output logic                        tx_interrupt
);

  localparam int CW = dist_pkg::CHAN_W;

  // Bit 0 rx, bit 1 tx
  logic [1:0]    int_bits;
  logic [1:0]    int_clr;
  logic [31:0]   discard_cnt [CHAN_COUNT];

  // Address decode
  logic [31:0]   disc_off;
  logic          disc_hit;
  logic [CW-1:0] disc_idx;
  logic [31:0]   rd_data;

  // Every access is taken at once
  assign mi_ardy = mi_wr | mi_rd;

  assign disc_off = mi_addr - dist_pkg::MI_ADDR_DISCARD_BASE;
  assign disc_hit = (mi_addr >= dist_pkg::MI_ADDR_DISCARD_BASE) &&
                    (disc_off < 32'(dist_pkg::MI_DISCARD_STRIDE * CHAN_COUNT));
  assign disc_idx = CW'(disc_off / 32'(dist_pkg::MI_DISCARD_STRIDE));

  assign int_clr = (mi_wr && mi_addr == dist_pkg::MI_ADDR_INT) ? mi_dwr[1:0] : 2'b00;

  // Read mux, unmapped addresses read as zero
  always_comb begin
    rd_data = '0;
    if (mi_addr == dist_pkg::MI_ADDR_ENABLE) begin
      rd_data[CHAN_COUNT-1:0] = chan_enable;
    end else if (mi_addr == dist_pkg::MI_ADDR_INT) begin
      rd_data[1:0] = int_bits;
    end else if (disc_hit) begin
      rd_data = discard_cnt[disc_idx];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chan_enable <= '1;
      int_bits    <= 2'b00;
      mi_drdy     <= 1'b0;
      for (int i = 0; i < CHAN_COUNT; i++) begin
        discard_cnt[i] <= '0;
      end
    end else begin
      mi_drdy <= mi_rd;
      if (mi_wr && mi_addr == dist_pkg::MI_ADDR_ENABLE) begin
        chan_enable <= mi_dwr[CHAN_COUNT-1:0];
      end
      // A new event wins over a clear in the same cycle
      int_bits <= (int_bits & ~int_clr) | {tx_frame_pulse, rx_frame_pulse};
      if (discard_pulse) begin
        discard_cnt[discard_chan] <= discard_cnt[discard_chan] + 1'b1;
      end
    end
  end

  // Read data one cycle after the access
  always_ff @(posedge clk) begin
    if (mi_rd) begin
      mi_drd <= rd_data;
    end
  end

  assign rx_interrupt = int_bits[0];
  assign tx_interrupt = int_bits[1];

endmodule

`default_nettype wire

// File: src/frame_dist_top.sv
/*
 * Frame distributor top level. Dispatcher, channel buffers,
 * round-robin drain and MI32 register block.
 */

`timescale 1ns/100ps
`default_nettype none

module frame_dist_top #(
  parameter int CHAN_COUNT = dist_pkg::CHAN_COUNT,
  parameter int BUF_DEPTH  = dist_pkg::DEF_BUF_DEPTH
) (
  input  wire                        clk,
  input  wire                        arst_n,
  // Receive stream
  input  wire dist_pkg::fl_word_t    rx_word,
  input  wire [dist_pkg::CHAN_W-1:0] rx_chan,
  input  wire                        rx_valid,
  output logic                       rx_ready,
  // Transmit stream
  output dist_pkg::tx_word_t         tx_word,
  output logic                       tx_valid,
  input  wire                        tx_ready,
  // MI32
  input  wire [31:0]                 mi_addr,
  input  wire [31:0]                 mi_dwr,
  input  wire                        mi_wr,
  input  wire                        mi_rd,
  output logic                       mi_ardy,
  output logic [31:0]                mi_drd,
  output logic                       mi_drdy,
  // Interrupts
  output logic                       rx_interrupt,
  output logic                       tx_interrupt
);

  // Dispatcher to buffers
  dist_pkg::fl_word_t          buf_wr_word;
  logic [CHAN_COUNT-1:0]       buf_wr_en;
  logic [CHAN_COUNT-1:0]       buf_credit_ret;

  // Buffers to drain
  dist_pkg::fl_word_t          head_word [CHAN_COUNT];
  logic [CHAN_COUNT-1:0]       head_valid;
  logic [CHAN_COUNT-1:0]       pop;

  // Control and events
  logic [CHAN_COUNT-1:0]       chan_enable;
  logic                        discard_pulse;
  logic [dist_pkg::CHAN_W-1:0] discard_chan;
  logic                        rx_frame_pulse;
  logic                        tx_frame_pulse;

  rx_dispatch #(
    .CHAN_COUNT (CHAN_COUNT),
    .BUF_DEPTH  (BUF_DEPTH)
  ) i_rx_dispatch (
    .clk            (clk),
    .arst_n         (arst_n),
    .rx_word        (rx_word),
    .rx_chan        (rx_chan),
    .rx_valid       (rx_valid),
    .rx_ready       (rx_ready),
    .chan_enable    (chan_enable),
    .buf_wr_word    (buf_wr_word),
    .buf_wr_en      (buf_wr_en),
    .buf_credit_ret (buf_credit_ret),
    .discard_pulse  (discard_pulse),
    .discard_chan   (discard_chan),
    .rx_frame_pulse (rx_frame_pulse)
  );

  // One buffer per channel
  for (genvar i = 0; i < CHAN_COUNT; i++) begin : g_buf
    chan_buffer #(
      .BUF_DEPTH (BUF_DEPTH)
    ) i_chan_buffer (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr_word    (buf_wr_word),
      .wr_en      (buf_wr_en[i]),
      .head_word  (head_word[i]),
      .head_valid (head_valid[i]),
      .pop        (pop[i]),
      .credit_ret (buf_credit_ret[i])
    );
  end

  tx_drain #(
    .CHAN_COUNT (CHAN_COUNT)
  ) i_tx_drain (
    .clk            (clk),
    .arst_n         (arst_n),
    .head_word      (head_word),
    .head_valid     (head_valid),
    .pop            (pop),
    .tx_word        (tx_word),
    .tx_valid       (tx_valid),
    .tx_ready       (tx_ready),
    .tx_frame_pulse (tx_frame_pulse)
  );

  mi_status #(
    .CHAN_COUNT (CHAN_COUNT)
  ) i_mi_status (
    .clk            (clk),
    .arst_n         (arst_n),
    .mi_addr        (mi_addr),
    .mi_dwr         (mi_dwr),
    .mi_wr          (mi_wr),
    .mi_rd          (mi_rd),
    .mi_ardy        (mi_ardy),
    .mi_drd         (mi_drd),
    .mi_drdy        (mi_drdy),
    .chan_enable    (chan_enable),
    .discard_pulse  (discard_pulse),
    .discard_chan   (discard_chan),
    .rx_frame_pulse (rx_frame_pulse),
    .tx_frame_pulse (tx_frame_pulse),
    .rx_interrupt   (rx_interrupt),
    .tx_interrupt   (tx_interrupt)
  );

endmodule

`default_nettype wire

// File: test/frame_dist_tb.sv
/*
 * Frame distributor testbench. Replays the golden record file on the
 * receive stream and MI32, checks transmit words, counters, interrupts.
 */

`timescale 1ns/100ps
`default_nettype none

module frame_dist_tb;

  localparam int CHAN_COUNT = dist_pkg::CHAN_COUNT;
  localparam int BUF_DEPTH  = dist_pkg::DEF_BUF_DEPTH;
  // Cycles any single wait may take
  localparam int TIMEOUT    = 2000;

  logic                        clk;
  logic                        arst_n;
  dist_pkg::fl_word_t          rx_word;
  logic [dist_pkg::CHAN_W-1:0] rx_chan;
  logic                        rx_valid;
  logic                        rx_ready;
  dist_pkg::tx_word_t          tx_word;
  logic                        tx_valid;
  logic                        tx_ready;
  logic [31:0]                 mi_addr;
  logic [31:0]                 mi_dwr;
  logic                        mi_wr;
  logic                        mi_rd;
  logic                        mi_ardy;
  logic [31:0]                 mi_drd;
  logic                        mi_drdy;
  logic                        rx_interrupt;
  logic                        tx_interrupt;

  // Expected transmit words, one queue per channel
  dist_pkg::fl_word_t exp_q [CHAN_COUNT][$];

  string       cur_test;
  int          tx_mode;
  logic [15:0] lfsr_state;
  logic        order_check;
  logic        saw_backpressure;

  frame_dist_top #(
    .CHAN_COUNT (CHAN_COUNT),
    .BUF_DEPTH  (BUF_DEPTH)
  ) i_frame_dist_top (
    .clk          (clk),
    .arst_n       (arst_n),
    .rx_word      (rx_word),
    .rx_chan      (rx_chan),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .tx_word      (tx_word),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .mi_addr      (mi_addr),
    .mi_dwr       (mi_dwr),
    .mi_wr        (mi_wr),
    .mi_rd        (mi_rd),
    .mi_ardy      (mi_ardy),
    .mi_drd       (mi_drd),
    .mi_drdy      (mi_drdy),
    .rx_interrupt (rx_interrupt),
    .tx_interrupt (tx_interrupt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int pending_words();
    int total;
    total = 0;
    for (int c = 0; c < CHAN_COUNT; c++) begin
      total += exp_q[c].size();
    end
    return total;
  endfunction

  task automatic fail_run(input string why);
    $display("%0s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else
      fail_run($sformatf("FAILED %0s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_fields(input int got, input int want);
    assert (got == want) else fail_run("Malformed record in the golden file");
  endtask

  // One receive word, held until the DUT takes it
  task automatic send_word(input int ch, input dist_pkg::fl_word_t w);
    int waited;
    rx_word  = w;
    rx_chan  = ch[dist_pkg::CHAN_W-1:0];
    rx_valid = 1'b1;
    waited   = 0;
    @(negedge clk);
    while (!rx_ready) begin
      waited++;
      assert (waited < TIMEOUT) else fail_run("Receive stream never became ready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    rx_valid = 1'b0;
  endtask

  // Whole frame with data base+i, expectations queued before sending
  task automatic send_frame(input int ch, input int words, input logic [31:0] base,
                            input int rem, input int keep);
    dist_pkg::fl_word_t w;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < words; i++) begin
        w.data = base + 32'(i);
        w.sof  = (i == 0);
        w.eof  = (i == words - 1);
        w.rem  = w.eof ? rem[1:0] : 2'd3;
        if (pass == 0 && keep != 0) begin
          exp_q[ch].push_back(w);
        end else if (pass == 1) begin
          send_word(ch, w);
        end
      end
    end
  endtask

  task automatic mi_write(input logic [31:0] addr, input logic [31:0] data);
    mi_addr = addr;
    mi_dwr  = data;
    mi_wr   = 1'b1;
    @(negedge clk);
    assert (mi_ardy) else fail_run("MI32 write was not accepted");
    @(posedge clk);
    #1;
    mi_wr = 1'b0;
  endtask

  task automatic mi_read(input logic [31:0] addr, output logic [31:0] data);
    int waited;
    mi_addr = addr;
    mi_rd   = 1'b1;
    waited  = 0;
    @(negedge clk);
    assert (mi_ardy) else fail_run("MI32 read was not accepted");
    @(posedge clk);
    #1;
    mi_rd = 1'b0;
    while (!mi_drdy) begin
      waited++;
      assert (waited < TIMEOUT) else fail_run("MI32 read data never arrived");
      @(posedge clk);
      #1;
    end
    data = mi_drd;
    @(posedge clk);
    #1;
  endtask

  // Until every expected transmit word has been seen
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_words() != 0) begin
      waited++;
      assert (waited < TIMEOUT) else fail_run("Transmit stream stopped before all frames left");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // --------------------------------------------------------------------------
  // Transmit throttle and monitor
  // --------------------------------------------------------------------------

  // Mode 0 always ready, 1 to 4 ANDs that many LFSR bits, 7 stalls
  initial begin : tx_throttle
    logic ready_bit;
    tx_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      ready_bit = (tx_mode != 7);
      for (int b = 0; b < tx_mode && tx_mode != 7; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        ready_bit  = ready_bit & lfsr_state[0];
      end
      tx_ready = ready_bit;
    end
  end

  // Sampled at the falling edge where every signal is settled
  initial begin : tx_monitor
    dist_pkg::fl_word_t          exp_word;
    logic [dist_pkg::CHAN_W-1:0] ch;
    logic [dist_pkg::CHAN_W-1:0] prev_chan;
    logic                        have_prev;
    have_prev = 1'b0;
    prev_chan = '0;
    forever begin
      @(negedge clk);
      if (rx_valid && !rx_ready) begin
        saw_backpressure = 1'b1;
      end
      if (!order_check) begin
        have_prev = 1'b0;
      end
      if (arst_n && tx_valid && tx_ready) begin
        ch = tx_word.chan;
        assert (exp_q[ch].size() > 0) else
          fail_run($sformatf("Unexpected transmit word on channel %0d in %0s", ch, cur_test));
        if (exp_q[ch].size() > 0) begin
          exp_word = exp_q[ch].pop_front();
          check_value($sformatf("%0s chan %0d word", cur_test, ch),
                      64'(exp_word), 64'(tx_word.word));
        end
        // Next frame must come from the next channel in rotation, wrapping at the last
        if (order_check && have_prev && tx_word.word.sof) begin
          check_value($sformatf("%0s rotation", cur_test),
                      64'((int'(prev_chan) + 1) % CHAN_COUNT), 64'(ch));
        end
        if (tx_word.word.eof) begin
          prev_chan = ch;
          have_prev = order_check;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Golden file replay
  // --------------------------------------------------------------------------

  initial begin : main
    int                 fd;
    int                 code;
    logic [8*16-1:0]    kind;
    logic [8*32-1:0]    name_buf;
    logic [8*128-1:0]   line_buf;
    int                 f_ch;
    int                 f_n;
    int                 f_sof;
    int                 f_eof;
    int                 f_rem;
    int                 f_keep;
    logic [31:0]        f_data;
    logic [31:0]        f_val;
    dist_pkg::fl_word_t w;

    arst_n           = 1'b0;
    rx_word          = '0;
    rx_chan          = '0;
    rx_valid         = 1'b0;
    mi_addr          = '0;
    mi_dwr           = '0;
    mi_wr            = 1'b0;
    mi_rd            = 1'b0;
    cur_test         = "reset";
    tx_mode          = 0;
    lfsr_state       = 16'd14;
    order_check      = 1'b0;
    saw_backpressure = 1'b0;

    fd = $fopen("test/golden_frames.txt", "r");
    assert (fd != 0) else fail_run("Cannot open test/golden_frames.txt");

    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_value("reset_state", 64'd0,
                64'({rx_ready, tx_valid, mi_drdy, rx_interrupt, tx_interrupt}));
    @(posedge clk);
    #1;

    while (!$feof(fd)) begin
      kind = '0;
      code = $fscanf(fd, "%s", kind);
      if (code == 1) begin
        case (kind)
          "#": code = $fgets(line_buf, fd);
          "N": begin
            check_fields($fscanf(fd, "%s", name_buf), 1);
            cur_test         = $sformatf("%0s", name_buf);
            saw_backpressure = 1'b0;
          end
          "R", "T": begin
            code = $fscanf(fd, "%d %h %d %d %d", f_ch, f_data, f_sof, f_eof, f_rem);
            check_fields(code, 5);
            w.data = f_data;
            w.sof  = f_sof[0];
            w.eof  = f_eof[0];
            w.rem  = f_rem[1:0];
            if (kind == "T") begin
              exp_q[f_ch].push_back(w);
            end else begin
              send_word(f_ch, w);
            end
          end
          "F": begin
            code = $fscanf(fd, "%d %d %h %d %d", f_ch, f_n, f_data, f_rem, f_keep);
            check_fields(code, 5);
            send_frame(f_ch, f_n, f_data, f_rem, f_keep);
          end
          "W": begin
            check_fields($fscanf(fd, "%h %h", f_data, f_val), 2);
            mi_write(f_data, f_val);
          end
          "C": begin
            check_fields($fscanf(fd, "%h %h", f_data, f_val), 2);
            mi_read(f_data, w.data);
            check_value($sformatf("%0s reg %h", cur_test, f_data), 64'(f_val), 64'(w.data));
          end
          "I": begin
            check_fields($fscanf(fd, "%h", f_val), 1);
            check_value($sformatf("%0s interrupts", cur_test), 64'(f_val),
                        64'({tx_interrupt, rx_interrupt}));
          end
          "M": check_fields($fscanf(fd, "%d", tx_mode), 1);
          "O": begin
            check_fields($fscanf(fd, "%d", f_val), 1);
            order_check = f_val[0];
          end
          "D": wait_drain();
          "B": begin
            assert (saw_backpressure) else
              fail_run($sformatf("No receive back-pressure seen in %0s", cur_test));
            saw_backpressure = 1'b0;
          end
          default: fail_run("Unknown record kind in the golden file");
        endcase
      end
    end
    $fclose(fd);
    wait_drain();

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/golden_frames.txt
# Records: N test | R/T chan data sof eof rem | F chan words base rem keep | W addr data
# C addr value | I {tx,rx} irq | M tx_mode (0 ready, 1-4 LFSR bits, 7 stall) | O order | D | B
N basic_frames
M 0
T 0 A0000001 1 0 3
T 0 A0000002 0 1 1
R 0 A0000001 1 0 3
R 0 A0000002 0 1 1
T 3 B0000001 1 1 2
R 3 B0000001 1 1 2
D
N interrupts
I 3
W 4 3
C 4 0
I 0
N channel_order
M 1
F 1 5 10000000 0 1
F 2 3 20000000 3 1
F 1 4 11000000 2 1
F 0 7 30000000 1 1
D
N backpressure
M 3
F 1 24 40000000 1 1
F 1 6 41000000 3 1
B
D
N discard
M 1
W 0 B
F 2 4 50000000 0 0
F 2 2 51000000 1 0
F 0 3 52000000 2 1
D
C 18 2
C 10 0
N round_robin
W 0 F
M 7
O 1
F 2 3 60000000 0 1
F 0 3 61000000 1 1
F 3 3 62000000 2 1
F 1 3 63000000 3 1
M 0
D
O 0
I 3

// File: vlog.f
src/dist_pkg.sv
src/rx_dispatch.sv
src/chan_buffer.sv
src/tx_drain.sv
src/mi_status.sv
src/frame_dist_top.sv
test/frame_dist_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the frame distributor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module frame_dist_tb \
  -Mdir obj_dir -o frame_dist_sim \
  && ./obj_dir/frame_dist_sim 2>&1 | tee sim.log
[ -s sim.log ] && ! grep -q "Verification failed" sim.log \
  && echo "Simulation run OK" \
  || { echo "Simulation run FAILED"; exit 1; }
